// File: include/link_defines.svh
`ifndef LINK_DEFINES_SVH
`define LINK_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~
// serial line timing
// ~~~~~~~~~~~~~~~~~~~~

`define LINK_BIT_CYC 4 // clocks per serial bit.

// ~~~~~~~~~~~~~~~~~~~~
// APB register map
// ~~~~~~~~~~~~~~~~~~~~

`define LINK_ADDR_W 4
`define LINK_DATA_W 32

`define LINK_REG_SEND   4'h0
`define LINK_REG_STATUS 4'h4
`define LINK_REG_READ   4'h8
`define LINK_REG_INDEX  4'hc

`endif

// File: design/link_pkg.sv
`include "link_defines.svh"

package link_pkg;

    typedef logic [3:0] nib_t; // packet type, packet data or index.
    typedef logic [`LINK_ADDR_W-1:0] addr_t;
    typedef logic [`LINK_DATA_W-1:0] data_t;

    typedef struct packed {
        nib_t btype;
        nib_t bdata;
    } pkt_t;

    // packet type codes on the cable.
    localparam nib_t BAG_INIT   = 4'd0;
    localparam nib_t BAG_ACK    = 4'd1;
    localparam nib_t BAG_NAK    = 4'd2;
    localparam nib_t BAG_STALL  = 4'd3;
    localparam nib_t BAG_DIDX   = 4'd5;
    localparam nib_t BAG_DPARAM = 4'd6;
    localparam nib_t BAG_DDIDX  = 4'd7;
    localparam nib_t BAG_DLINK  = 4'd8;
    localparam nib_t BAG_DTYPE  = 4'd9;
    localparam nib_t BAG_DTEMP  = 4'd10;
    localparam nib_t BAG_DHEAD  = 4'd12;
    localparam nib_t BAG_DATA0  = 4'd13;
    localparam nib_t BAG_DATA1  = 4'd14;

    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        addr_t paddr;
        data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        data_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

endpackage

// File: design/link_ctrl.sv
`timescale 1ns/1ns

module link_ctrl (
    input  logic           clk,
    input  logic           rst,
    input  logic           fs_send,
    input  link_pkg::nib_t send_btype,
    output logic           fd_send,
    output logic           send_err,
    output logic           fs_read,
    input  logic           fd_read,
    output link_pkg::pkt_t read_pkt,
    output link_pkg::nib_t device_idx,
    output link_pkg::nib_t data_idx,
    output logic           fs_tx,
    input  logic           fd_tx,
    output link_pkg::nib_t tx_btype,
    input  logic           fs_rx,
    output logic           fd_rx,
    input  link_pkg::pkt_t rx_pkt
);
    import link_pkg::*;

    typedef enum logic [3:0] {
        IDLE,
        SEND_LOAD,
        SEND_RELOAD,
        SEND_DATA,
        RECV_WAIT,
        RECV_TAKE,
        RECV_DONE,
        SEND_DONE,
        READ_DATA,
        READ_TAKE,
        READ_SKIP,
        ACK_LOAD,
        ACK_SEND,
        NAK_LOAD,
        NAK_SEND,
        READ_DONE
    } state_t;

    state_t state;
    state_t next_state;
    logic   resend; // last reply was a NAK.

    function automatic logic is_cfg(input nib_t btype);
        return (btype == BAG_DIDX) || (btype == BAG_DPARAM) || (btype == BAG_DDIDX);
    endfunction

    assign fd_send = (state == SEND_DONE);
    assign fs_read = (state == READ_DONE);
    assign fs_tx   = (state == SEND_DATA) || (state == ACK_SEND) || (state == NAK_SEND);
    assign fd_rx   = (state == RECV_DONE) || (state == READ_TAKE) || (state == READ_SKIP);

    // ~~~~~~~~~~~~~~~~~~~~
    // state machine
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (fs_send) next_state = SEND_LOAD; // the processor wins over the far end.
                else if (fs_rx) next_state = READ_DATA;
            end
            SEND_LOAD:   next_state = SEND_DATA;
            SEND_RELOAD: next_state = SEND_DATA;
            SEND_DATA:   if (fd_tx) next_state = RECV_WAIT;
            RECV_WAIT:   if (fs_rx) next_state = RECV_TAKE;
            RECV_TAKE:   next_state = RECV_DONE;
            RECV_DONE:   if (!fs_rx) next_state = resend ? SEND_RELOAD : SEND_DONE;
            SEND_DONE:   if (!fs_send) next_state = IDLE;
            READ_DATA:   next_state = is_cfg(rx_pkt.btype) ? READ_TAKE : READ_SKIP;
            READ_TAKE:   if (!fs_rx) next_state = ACK_LOAD;
            READ_SKIP:   if (!fs_rx) next_state = NAK_LOAD;
            ACK_LOAD:    next_state = ACK_SEND;
            ACK_SEND:    if (fd_tx) next_state = READ_DONE;
            NAK_LOAD:    next_state = NAK_SEND;
            NAK_SEND:    if (fd_tx) next_state = READ_DONE;
            READ_DONE:   if (fd_read) next_state = IDLE;
            default:     next_state = IDLE;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // reply decode
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resend   <= 1'b0;
            send_err <= 1'b0;
        end else if (state == SEND_LOAD) begin
            resend   <= 1'b0;
            send_err <= 1'b0;
        end else if (state == RECV_TAKE) begin
            resend   <= (rx_pkt.btype == BAG_NAK);
            // anything but ACK or NAK closes the send with an error.
            send_err <= (rx_pkt.btype != BAG_ACK) && (rx_pkt.btype != BAG_NAK);
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            SEND_LOAD:   tx_btype <= send_btype;
            SEND_RELOAD: if (tx_btype == BAG_DATA0) tx_btype <= BAG_DATA1; // toggle on retry.
            ACK_LOAD:    tx_btype <= BAG_ACK;
            NAK_LOAD:    tx_btype <= BAG_NAK;
            default:     tx_btype <= tx_btype;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // received packet and indices
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            read_pkt   <= '{btype: BAG_INIT, bdata: BAG_INIT};
            device_idx <= '0;
            data_idx   <= '0;
        end else if (state == READ_DATA) begin
            read_pkt <= '{btype: BAG_INIT, bdata: BAG_INIT}; // stays clear for a rejected type.
            if (rx_pkt.btype == BAG_DIDX) device_idx <= rx_pkt.bdata;
            if (rx_pkt.btype == BAG_DDIDX) data_idx <= rx_pkt.bdata;
        end else if (state == READ_TAKE) begin
            read_pkt <= rx_pkt;
        end
    end

endmodule

// File: design/link_tx.sv
`timescale 1ns/1ns
`include "link_defines.svh"

module link_tx (
    input  logic           clk,
    input  logic           rst,
    input  logic           fs_tx,
    input  link_pkg::nib_t tx_btype,
    output logic           fd_tx,
    output logic           tx_line
);

    localparam int FRAME_BITS = 6; // start, four type bits, stop.
    localparam int CYC_W = $clog2(`LINK_BIT_CYC);
    localparam logic [CYC_W-1:0] LAST_CYC = CYC_W'(`LINK_BIT_CYC - 1);
    localparam logic [CYC_W-1:0] PRE_CYC = CYC_W'(`LINK_BIT_CYC - 2);
    localparam logic [2:0] LAST_BIT = 3'(FRAME_BITS - 1);

    logic                  busy;
    logic [CYC_W-1:0]      cyc_cnt;
    logic [2:0]            bit_cnt;
    logic [FRAME_BITS-1:0] shreg;

    // the shifter fills with ones, so the line rests high between frames.
    assign tx_line = shreg[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            cyc_cnt <= '0;
            bit_cnt <= '0;
            shreg   <= '1;
            fd_tx   <= 1'b0;
        end else if (!busy) begin
            fd_tx <= 1'b0;
            if (fs_tx) begin
                busy    <= 1'b1;
                cyc_cnt <= '0;
                bit_cnt <= '0;
                shreg   <= {1'b1, tx_btype, 1'b0};
            end
        end else begin
            fd_tx <= (bit_cnt == LAST_BIT) && (cyc_cnt == PRE_CYC); // last stop cycle.
            if (cyc_cnt == LAST_CYC) begin
                cyc_cnt <= '0;
                bit_cnt <= bit_cnt + 1'b1;
                shreg   <= {1'b1, shreg[FRAME_BITS-1:1]};
                if (bit_cnt == LAST_BIT) busy <= 1'b0;
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
        end
    end

endmodule

// File: design/link_rx.sv
`timescale 1ns/1ns
`include "link_defines.svh"

module link_rx (
    input  logic           clk,
    input  logic           rst,
    input  logic           rx_line,
    input  logic           fd_rx,
    output logic           fs_rx,
    output link_pkg::pkt_t rx_pkt
);

    localparam int CYC_W = $clog2(`LINK_BIT_CYC);
    localparam logic [CYC_W-1:0] LAST_CYC = CYC_W'(`LINK_BIT_CYC - 1);
    localparam logic [CYC_W-1:0] HALF_CYC = CYC_W'(`LINK_BIT_CYC / 2 - 1);

    typedef enum logic [1:0] {R_IDLE, R_START, R_DATA, R_STOP} rx_state_t;

    rx_state_t        state;
    logic [2:0]       line_sync; // two sync flops and one history flop.
    logic             line;
    logic             start_edge;
    logic [CYC_W-1:0] cyc_cnt;
    logic [2:0]       bit_cnt;
    logic [7:0]       shreg;
    logic             frame_ok;
    logic             take;

    assign line       = line_sync[1];
    assign start_edge = !line_sync[1] && line_sync[2];
    assign take       = frame_ok && !fs_rx && !fd_rx; // frames behind a held packet are lost.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            line_sync <= '1;
            state     <= R_IDLE;
            cyc_cnt   <= '0;
            bit_cnt   <= '0;
            frame_ok  <= 1'b0;
        end else begin
            line_sync <= {line_sync[1:0], rx_line};
            frame_ok  <= 1'b0;
            case (state)
                R_IDLE: begin
                    cyc_cnt <= '0;
                    if (start_edge) state <= R_START;
                end
                R_START: begin
                    if (cyc_cnt == HALF_CYC) begin
                        cyc_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= line ? R_IDLE : R_DATA; // a glitch is not a start bit.
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                R_DATA: begin
                    if (cyc_cnt == LAST_CYC) begin
                        cyc_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= R_STOP;
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                R_STOP: begin
                    if (cyc_cnt == LAST_CYC) begin
                        frame_ok <= line;
                        state    <= R_IDLE;
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == R_DATA && cyc_cnt == LAST_CYC) shreg <= {line, shreg[7:1]};
        if (take) rx_pkt <= '{btype: shreg[3:0], bdata: shreg[7:4]};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fs_rx <= 1'b0;
        end else if (fs_rx && fd_rx) begin
            fs_rx <= 1'b0;
        end else if (take) begin
            fs_rx <= 1'b1;
        end
    end

endmodule

// File: design/link_apb_regs.sv
`timescale 1ns/1ns
`include "link_defines.svh"

module link_apb_regs (
    input  logic               clk,
    input  logic               rst,
    input  link_pkg::apb_req_t apb_req,
    output link_pkg::apb_rsp_t apb_rsp,
    output logic               fs_send,
    output link_pkg::nib_t     send_btype,
    input  logic               fd_send,
    input  logic               send_err,
    input  logic               fs_read,
    output logic               fd_read,
    input  link_pkg::pkt_t     read_pkt,
    input  link_pkg::nib_t     device_idx,
    input  link_pkg::nib_t     data_idx
);
    import link_pkg::*;

    logic  wr_acc;
    logic  rd_acc;
    logic  send_go;
    logic  st_ok;
    logic  st_err;
    data_t rdata;

    // ~~~~~~~~~~~~~~~~~~~~
    // access decode
    // ~~~~~~~~~~~~~~~~~~~~

    assign wr_acc = apb_req.psel && apb_req.penable && apb_req.pwrite;
    assign rd_acc = apb_req.psel && apb_req.penable && !apb_req.pwrite;

    // a send starts only once the previous handshake has fully closed.
    assign send_go = wr_acc && (apb_req.paddr == `LINK_REG_SEND) && !fs_send && !fd_send;

    // ~~~~~~~~~~~~~~~~~~~~
    // send handshake
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fs_send    <= 1'b0;
            send_btype <= '0;
            st_ok      <= 1'b0;
            st_err     <= 1'b0;
        end else if (send_go) begin
            fs_send    <= 1'b1;
            send_btype <= apb_req.pwdata[3:0];
            st_ok      <= 1'b0;
            st_err     <= 1'b0;
        end else if (fs_send && fd_send) begin
            fs_send <= 1'b0;
            st_ok   <= !send_err;
            st_err  <= send_err;
        end
    end

    // reading READ with a packet pending hands it back to the controller.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fd_read <= 1'b0;
        end else begin
            fd_read <= rd_acc && (apb_req.paddr == `LINK_REG_READ) && fs_read && !fd_read;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // read data
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        rdata = '0;
        case (apb_req.paddr)
            `LINK_REG_SEND:   rdata[3:0] = send_btype;
            `LINK_REG_STATUS: rdata[3:0] = {fs_read, st_err, st_ok, fs_send};
            `LINK_REG_READ:   rdata[7:0] = {read_pkt.bdata, read_pkt.btype};
            `LINK_REG_INDEX:  rdata[7:0] = {data_idx, device_idx};
            default:          rdata = '0;
        endcase
    end

    assign apb_rsp = '{prdata: rdata, pready: 1'b1, pslverr: 1'b0}; // no wait states.

endmodule

// File: design/link_top.sv
`timescale 1ns/1ns

module link_top (
    input  logic               clk,
    input  logic               rst,
    input  link_pkg::apb_req_t apb_req,
    output link_pkg::apb_rsp_t apb_rsp,
    input  logic               rx_line,
    output logic               tx_line
);
    import link_pkg::*;

    // processor side.
    logic fs_send;
    logic fd_send;
    logic send_err;
    nib_t send_btype;
    logic fs_read;
    logic fd_read;
    pkt_t read_pkt;
    nib_t device_idx;
    nib_t data_idx;

    // line side.
    logic fs_tx;
    logic fd_tx;
    nib_t tx_btype;
    logic fs_rx;
    logic fd_rx;
    pkt_t rx_pkt;

    link_apb_regs i_regs (
        .clk, .rst, .apb_req, .apb_rsp,
        .fs_send, .send_btype, .fd_send, .send_err,
        .fs_read, .fd_read, .read_pkt, .device_idx, .data_idx
    );

    link_ctrl i_ctrl (
        .clk, .rst,
        .fs_send, .send_btype, .fd_send, .send_err,
        .fs_read, .fd_read, .read_pkt, .device_idx, .data_idx,
        .fs_tx, .fd_tx, .tx_btype, .fs_rx, .fd_rx, .rx_pkt
    );

    link_tx i_tx (
        .clk, .rst, .fs_tx, .tx_btype, .fd_tx, .tx_line
    );

    link_rx i_rx (
        .clk, .rst, .rx_line, .fd_rx, .fs_rx, .rx_pkt
    );

endmodule

// File: tests/link_assertions.sv
`timescale 1ns/1ns

module link_assertions (
    input logic           clk,
    input logic           rst,
    input logic           fs_send,
    input logic           fd_send,
    input logic           fs_read,
    input logic           fd_read,
    input logic           fs_tx,
    input logic           fd_tx,
    input logic           fs_rx,
    input logic           fd_rx,
    input link_pkg::pkt_t rx_pkt
);

    int fail_cnt = 0; // read by the testbench at the end of the run.

    // ~~~~~~~~~~~~~~~~~~~~
    // handshake rules
    // ~~~~~~~~~~~~~~~~~~~~

    tx_held: assert property (@(posedge clk) disable iff (rst) fs_tx && !fd_tx |=> fs_tx)
        else begin $error("fs_tx dropped before fd_tx"); fail_cnt++; end

    // the held packet must not move under the controller.
    rx_stable: assert property (@(posedge clk) disable iff (rst)
        fs_rx |=> (!fs_rx || $stable(rx_pkt)))
        else begin $error("rx_pkt changed while fs_rx was high"); fail_cnt++; end

    // the regs block and the serializer answer only their own handshake.
    tx_vs_read: assert property (@(posedge clk) disable iff (rst)
        !((fs_tx && fd_read) || (fs_read && fd_tx)))
        else begin $error("transmit and read handshakes overlapped"); fail_cnt++; end

    send_done: assert property (@(posedge clk) disable iff (rst) $rose(fd_send) |-> fs_send)
        else begin $error("fd_send rose without fs_send"); fail_cnt++; end

endmodule

bind link_ctrl link_assertions i_link_assertions (
    .clk, .rst, .fs_send, .fd_send, .fs_read, .fd_read,
    .fs_tx, .fd_tx, .fs_rx, .fd_rx, .rx_pkt
);

// File: tests/link_tb.sv
`timescale 1ns/1ns
`include "link_defines.svh"

module link_tb;
    import link_pkg::*;

    localparam int FRAME_WAIT   = 300; // cycles to wait for a frame on tx_line.
    localparam int STATUS_POLLS = 100;

    logic     clk;
    logic     rst;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     rx_line;
    logic     tx_line;
    int       seed;
    nib_t     exp_dev;
    nib_t     exp_data;
    logic     exp_ok;
    logic     exp_err;

    link_top i_link_top (.clk, .rst, .apb_req, .apb_rsp, .rx_line, .tx_line);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // checks and bus tasks
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic check_eq(input string name, input data_t got, input data_t exp);
        assert (got === exp) else begin
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timed out at %0t while waiting for %s", $time, what);
        $display("TEST FAIL");
        $fatal(1, "timeout");
    endtask

    task automatic apb_write(input addr_t addr, input data_t data);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic apb_read(input addr_t addr, output data_t data);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        data = apb_rsp.prdata; // access phase.
        check_eq("pready", apb_rsp.pready, 1'b1);
        check_eq("pslverr", apb_rsp.pslverr, 1'b0);
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic wait_status(input int bit_pos, input logic value);
        data_t st;
        int    polls;
        polls = 0;
        apb_read(`LINK_REG_STATUS, st);
        while (st[bit_pos] !== value && polls < STATUS_POLLS) begin
            polls++;
            apb_read(`LINK_REG_STATUS, st);
        end
        if (st[bit_pos] !== value) timeout_fail("a STATUS bit to change");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // far end of the cable
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic peer_send(input nib_t btype, input nib_t bdata);
        logic [9:0] bits;
        int         i;
        bits = {1'b1, bdata, btype, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            rx_line <= bits[i];
            repeat (`LINK_BIT_CYC - 1) @(posedge clk);
        end
    endtask

    task automatic peer_recv(output nib_t btype);
        int waited;
        int i;
        waited = 0;
        @(negedge clk);
        while (tx_line !== 1'b0 && waited < FRAME_WAIT) begin
            waited++;
            @(negedge clk);
        end
        if (tx_line !== 1'b0) timeout_fail("a frame on tx_line");
        repeat (`LINK_BIT_CYC / 2) @(negedge clk); // middle of the start bit.
        check_eq("tx_line start bit", tx_line, 1'b0);
        for (i = 0; i < 4; i++) begin
            repeat (`LINK_BIT_CYC) @(negedge clk);
            btype[i] = tx_line;
        end
        repeat (`LINK_BIT_CYC) @(negedge clk);
        check_eq("tx_line stop bit", tx_line, 1'b1);
    endtask

    function automatic logic accepted_type(input nib_t btype);
        return btype inside {BAG_DIDX, BAG_DPARAM, BAG_DDIDX};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // scenarios
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic recv_packet(input nib_t btype, input nib_t bdata);
        nib_t  reply;
        data_t rd;
        peer_send(btype, bdata);
        peer_recv(reply);
        check_eq("reply btype", reply, accepted_type(btype) ? BAG_ACK : BAG_NAK);
        if (btype == BAG_DIDX) exp_dev = bdata;
        if (btype == BAG_DDIDX) exp_data = bdata;
        wait_status(3, 1'b1);
        apb_read(`LINK_REG_READ, rd);
        check_eq("READ", rd, accepted_type(btype) ? data_t'({bdata, btype}) : '0);
        apb_read(`LINK_REG_STATUS, rd);
        check_eq("STATUS", rd, data_t'({1'b0, exp_err, exp_ok, 1'b0}));
        apb_read(`LINK_REG_INDEX, rd);
        check_eq("INDEX", rd, data_t'({exp_data, exp_dev}));
    endtask

    task automatic send_packet(input nib_t btype, input int naks, input nib_t last_reply);
        nib_t  exp_type;
        nib_t  got;
        data_t rd;
        int    i;
        exp_type = btype;
        apb_write(`LINK_REG_SEND, data_t'(btype));
        for (i = 0; i < naks; i++) begin
            peer_recv(got);
            check_eq("tx frame btype", got, exp_type);
            peer_send(BAG_NAK, nib_t'($random(seed)));
            if (exp_type == BAG_DATA0) exp_type = BAG_DATA1; // retry rule of the link.
        end
        peer_recv(got);
        check_eq("tx frame btype", got, exp_type);
        peer_send(last_reply, nib_t'($random(seed)));
        wait_status(0, 1'b0);
        exp_ok  = (last_reply == BAG_ACK);
        exp_err = !exp_ok;
        apb_read(`LINK_REG_STATUS, rd);
        check_eq("STATUS", rd, data_t'({1'b0, exp_err, exp_ok, 1'b0}));
        apb_read(`LINK_REG_INDEX, rd);
        check_eq("INDEX", rd, data_t'({exp_data, exp_dev}));
    endtask

    initial begin
        data_t rd;
        nib_t  t;
        nib_t  bad;
        seed     = 32'hc374_ac03;
        rst      = 1'b1;
        apb_req  = '0;
        rx_line  = 1'b1;
        exp_dev  = '0;
        exp_data = '0;
        exp_ok   = 1'b0;
        exp_err  = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        apb_read(`LINK_REG_STATUS, rd);
        check_eq("STATUS", rd, '0);
        apb_read(`LINK_REG_READ, rd);
        check_eq("READ", rd, '0);
        apb_read(`LINK_REG_INDEX, rd);
        check_eq("INDEX", rd, '0);
        check_eq("tx_line", tx_line, 1'b1);

        repeat (10) begin
            case ($unsigned($random(seed)) % 3)
                0: t = BAG_DIDX;
                1: t = BAG_DPARAM;
                default: t = BAG_DDIDX;
            endcase
            recv_packet(t, nib_t'($random(seed)));
        end
        repeat (5) begin
            t = nib_t'($random(seed));
            if (accepted_type(t)) t = t ^ 4'h8; // moves 5..7 onto 13..15.
            recv_packet(t, nib_t'($random(seed)));
        end

        repeat (4) send_packet(nib_t'($random(seed)), 0, BAG_ACK);
        send_packet(BAG_DATA0, 3, BAG_ACK);
        repeat (6) begin
            t = ($random(seed) & 1) ? BAG_DATA0 : nib_t'($random(seed));
            send_packet(t, $unsigned($random(seed)) % 4, BAG_ACK);
        end

        send_packet(nib_t'($random(seed)), 0, BAG_STALL);
        repeat (3) begin
            bad = nib_t'($random(seed));
            if (bad == BAG_ACK || bad == BAG_NAK) bad = BAG_STALL;
            send_packet(nib_t'($random(seed)), $unsigned($random(seed)) % 2, bad);
        end
        send_packet(BAG_DATA0, 1, BAG_ACK); // a clean send clears err again.

        if (i_link_top.i_ctrl.i_link_assertions.fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
design/link_pkg.sv
design/link_ctrl.sv
design/link_tx.sv
design/link_rx.sv
design/link_apb_regs.sv
design/link_top.sv
tests/link_assertions.sv
tests/link_tb.sv
